// File: Makefile
# Verilator build for the Sobel edge subsystem testbench

VERILATOR ?= verilator
TOP       ?= sobel_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= SIMULATION PASSED

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the run passes only if the pass line shows up in the output
run: compile
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_MSG)"; then \
		echo "run: pass"; \
	else \
		echo "run: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)

// File: include/sobel_defs.svh
/*
 * Sobel edge subsystem common definitions
 * Pixel width, line buffer depth and the register map of the Wishbone slave
 */

`ifndef SOBEL_DEFS_SVH
`define SOBEL_DEFS_SVH

// width of one grey pixel on the camera bus
`define SOBEL_PIX_W 8

// longest row the line buffers can hold
`define SOBEL_MAX_W 640

// byte address of the control word
// (enable, binary mode and threshold live here)
`define SOBEL_ADDR_CTRL 4'h0

// byte address of the read-only completed frame counter
`define SOBEL_ADDR_FCNT 4'h4

`endif

// File: tb.f
+incdir+include
verilog/sobel_pkg.sv
verilog/sobel_window_if.sv
verilog/sobel_line_window.sv
verilog/sobel_kernel.sv
verilog/sobel_wb_regs.sv
verilog/sobel_edge_top.sv
test/sobel_assertions.sv
test/sobel_tb.sv

// File: test/sobel_assertions.sv
/*
 * Sobel edge subsystem assertions
 * Stream sync latency and Wishbone acknowledge rules
 */

`timescale 1ns/1ps

module sobel_assertions (
    input logic pclk_i,
    input logic rst_i,
    input logic fsync_i,
    input logic rsync_i,
    input logic fsync_o,
    input logic rsync_o,
    input logic wb_cyc_i,
    input logic wb_stb_i,
    input logic wb_ack_o
);

    // the syncs leave exactly five cycles after they enter
    assert property (@(posedge pclk_i) disable iff (rst_i) fsync_o == $past(fsync_i, 5))
        else $error("output fsync is not the input fsync five cycles late");

    assert property (@(posedge pclk_i) disable iff (rst_i) rsync_o == $past(rsync_i, 5))
        else $error("output rsync is not the input rsync five cycles late");

    // rows only exist inside a frame
    assert property (@(posedge pclk_i) disable iff (rst_i) rsync_o |-> fsync_o)
        else $error("output rsync high outside a frame");

    // ack is a single pulse
    assert property (@(posedge pclk_i) disable iff (rst_i) wb_ack_o |=> !wb_ack_o)
        else $error("Wishbone ack held for more than one cycle");

    // and only answers a request seen on the previous edge
    assert property (@(posedge pclk_i) disable iff (rst_i)
                     wb_ack_o |-> $past(wb_cyc_i && wb_stb_i))
        else $error("Wishbone ack without a request");

endmodule

// File: test/sobel_tb.sv
/*
 * Sobel edge subsystem testbench
 * Random frames against a zero-fill reference model, Wishbone register checks
 */

`timescale 1ns/1ps
`include "sobel_defs.svh"

module sobel_tb;

    localparam int MAX_ROWS      = 7;
    localparam int MAX_COLS      = 20;
    localparam int ACK_TIMEOUT   = 20;
    localparam int FRAME_TIMEOUT = 40;

    logic                    pclk;
    logic                    rst;
    logic                    fsync;
    logic                    rsync;
    logic [`SOBEL_PIX_W-1:0] pdata;
    logic                    wb_cyc;
    logic                    wb_stb;
    logic                    wb_we;
    logic [3:0]              wb_adr;
    logic [31:0]             wb_dat_w;
    logic [31:0]             wb_dat_r;
    logic                    wb_ack;
    logic                    fsync_out;
    logic                    rsync_out;
    logic [`SOBEL_PIX_W-1:0] pdata_out;

    // model state, exp_pix travels with the stimulus so it lines up with the DUT
    logic [`SOBEL_PIX_W-1:0] exp_pix;
    logic [`SOBEL_PIX_W-1:0] frame_pix [0:MAX_ROWS-1][0:MAX_COLS-1];
    logic                    mode_enable;
    logic                    mode_binary;
    logic [7:0]              mode_thr;
    logic [9:0]              exp_q [$];
    logic [31:0]             rng_state;
    logic                    checking;
    logic                    pass_printed;
    logic                    fail_printed;
    int                      frames_done;

    sobel_edge_top i_dut (
        .pclk_i   (pclk),
        .rst_i    (rst),
        .fsync_i  (fsync),
        .rsync_i  (rsync),
        .pdata_i  (pdata),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat_w),
        .fsync_o  (fsync_out),
        .rsync_o  (rsync_out),
        .pdata_o  (pdata_out),
        .wb_dat_o (wb_dat_r),
        .wb_ack_o (wb_ack)
    );

    bind sobel_edge_top sobel_assertions u_assertions (.*);

    initial begin
        pclk = 1'b0;
        forever #5 pclk = ~pclk;
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] s;
        s = rng_state;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        rng_state = s;
        return s;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'(next_rand() % 32'(hi - lo + 1));
    endfunction

    // pixels above or left of the frame read as zero
    function automatic int pix_at(input int r, input int c);
        if (r < 0 || c < 0) begin
            return 0;
        end
        return int'(frame_pix[r][c]);
    endfunction

    // the window ending at (r, c) spans rows r-2..r and columns c-2..c
    function automatic logic [7:0] model_pixel(input int r, input int c);
        int gx;
        int gy;
        int mag;
        gx = pix_at(r - 2, c) + 2 * pix_at(r - 1, c) + pix_at(r, c)
           - pix_at(r - 2, c - 2) - 2 * pix_at(r - 1, c - 2) - pix_at(r, c - 2);
        gy = pix_at(r, c - 2) + 2 * pix_at(r, c - 1) + pix_at(r, c)
           - pix_at(r - 2, c - 2) - 2 * pix_at(r - 2, c - 1) - pix_at(r - 2, c);
        mag = (gx < 0 ? -gx : gx) + (gy < 0 ? -gy : gy);
        if (mag > 255) begin
            mag = 255;
        end
        if (!mode_enable) begin
            return frame_pix[r][c];
        end
        if (mode_binary) begin
            return (mag > int'(mode_thr)) ? 8'hff : 8'h00;
        end
        return 8'(mag);
    endfunction

    task automatic stop_with_failure(input string reason);
        fail_printed = 1'b1;
        $display("SIMULATION FAILED");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("[ERROR] time %0t: %s is %0h, expected %0h", $time, what, got, want);
            stop_with_failure("value mismatch");
        end
    endtask

    task automatic drive_cycle(input logic fs, input logic rs,
                               input logic [7:0] pix, input logic [7:0] want);
        @(posedge pclk);
        fsync   <= fs;
        rsync   <= rs;
        pdata   <= pix;
        exp_pix <= want;
    endtask

    // one classic cycle, held until ack and released on the next edge
    task automatic wb_access(input logic we, input logic [3:0] adr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int n;
        @(posedge pclk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdata;
        n = 0;
        do begin
            @(negedge pclk);
            n++;
            if (n > ACK_TIMEOUT) begin
                stop_with_failure("the Wishbone slave never raised ack");
            end
        end while (wb_ack !== 1'b1);
        rdata = wb_dat_r;
        @(posedge pclk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    // reserved bits get random junk that the slave has to drop
    task automatic set_ctrl(input logic en, input logic bin, input logic [7:0] thr);
        logic [31:0] word;
        logic [31:0] rd;
        word       = next_rand();
        word[0]    = en;
        word[1]    = bin;
        word[15:8] = thr;
        wb_access(1'b1, `SOBEL_ADDR_CTRL, word, rd);
        mode_enable = en;
        mode_binary = bin;
        mode_thr    = thr;
        wb_access(1'b0, `SOBEL_ADDR_CTRL, 32'd0, rd);
        check_value("control read back", rd, {16'h0, thr, 6'h0, bin, en});
    endtask

    task automatic run_frame();
        int rows;
        int cols;
        int n;
        rows = rand_range(4, MAX_ROWS);
        cols = rand_range(8, MAX_COLS);
        for (int r = 0; r < rows; r++) begin
            for (int c = 0; c < cols; c++) begin
                frame_pix[r][c] = 8'(next_rand());
            end
        end
        repeat (rand_range(1, 3)) drive_cycle(1'b1, 1'b0, 8'h00, 8'h00);
        for (int r = 0; r < rows; r++) begin
            for (int c = 0; c < cols; c++) begin
                drive_cycle(1'b1, 1'b1, frame_pix[r][c], model_pixel(r, c));
            end
            // blanking between rows, the window is all zero there
            repeat (rand_range(1, 4)) drive_cycle(1'b1, 1'b0, 8'h00, 8'h00);
        end
        drive_cycle(1'b0, 1'b0, 8'h00, 8'h00);
        n = 0;
        do begin
            @(negedge pclk);
            n++;
            if (n > FRAME_TIMEOUT) begin
                stop_with_failure("the output fsync did not fall at the end of a frame");
            end
        end while (fsync_out !== 1'b0);
        frames_done++;
        repeat (rand_range(2, 6)) drive_cycle(1'b0, 1'b0, 8'h00, 8'h00);
    endtask

    // an entry pushed now comes out of the DUT five edges later
    always @(negedge pclk) begin
        logic [9:0] want;
        if (checking) begin
            exp_q.push_back({fsync, rsync, exp_pix});
            if (exp_q.size() > 5) begin
                want = exp_q.pop_front();
                check_value("output fsync", 32'(fsync_out), 32'(want[9]));
                check_value("output rsync", 32'(rsync_out), 32'(want[8]));
                check_value("output pixel", 32'(pdata_out), 32'(want[7:0]));
            end
        end
    end

    initial begin
        logic [31:0] rd;
        rng_state    = 32'h76af;
        rst          = 1'b1;
        fsync        = 1'b0;
        rsync        = 1'b0;
        pdata        = '0;
        exp_pix      = '0;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_w     = '0;
        mode_enable  = 1'b0;
        mode_binary  = 1'b0;
        mode_thr     = '0;
        checking     = 1'b0;
        pass_printed = 1'b0;
        fail_printed = 1'b0;
        frames_done  = 0;
        repeat (5) @(posedge pclk);
        rst      <= 1'b0;
        checking <= 1'b1;

        // reset state, the kernel starts in bypass
        wb_access(1'b0, `SOBEL_ADDR_CTRL, 32'd0, rd);
        check_value("control after reset", rd, 32'd0);
        wb_access(1'b0, `SOBEL_ADDR_FCNT, 32'd0, rd);
        check_value("frame count after reset", rd, 32'd0);
        repeat (2) run_frame();

        // magnitude mode
        set_ctrl(1'b1, 1'b0, 8'h00);
        repeat (3) run_frame();

        // binary mode with a new threshold per frame
        repeat (4) begin
            set_ctrl(1'b1, 1'b1, 8'(next_rand()));
            run_frame();
        end

        // holes in the register map
        wb_access(1'b0, 4'h8, 32'd0, rd);
        check_value("read of address 0x8", rd, 32'd0);
        wb_access(1'b0, 4'hc, 32'd0, rd);
        check_value("read of address 0xc", rd, 32'd0);

        // the counter is read only
        wb_access(1'b0, `SOBEL_ADDR_FCNT, 32'd0, rd);
        check_value("frame count", rd, 32'(frames_done));
        wb_access(1'b1, `SOBEL_ADDR_FCNT, next_rand(), rd);
        wb_access(1'b0, `SOBEL_ADDR_FCNT, 32'd0, rd);
        check_value("frame count after write", rd, 32'(frames_done));

        repeat (8) drive_cycle(1'b0, 1'b0, 8'h00, 8'h00);
        pass_printed = 1'b1;
        $display("SIMULATION PASSED");
        $finish;
    end

    // a run stopped by an assertion still ends with the failure line
    final begin
        if (!pass_printed && !fail_printed) begin
            $display("SIMULATION FAILED");
        end
    end

endmodule

// File: verilog/sobel_edge_top.sv
/*
 * Sobel edge detection subsystem
 * Camera pixel stream in, edge stream out five cycles later, Wishbone control
 */

`timescale 1ns/1ps
`include "sobel_defs.svh"

module sobel_edge_top (
    input  logic                    pclk_i,
    input  logic                    rst_i,
    input  logic                    fsync_i,
    input  logic                    rsync_i,
    input  logic [`SOBEL_PIX_W-1:0] pdata_i,
    input  logic                    wb_cyc_i,
    input  logic                    wb_stb_i,
    input  logic                    wb_we_i,
    input  logic [3:0]              wb_adr_i,
    input  logic [31:0]             wb_dat_i,
    output logic                    fsync_o,
    output logic                    rsync_o,
    output logic [`SOBEL_PIX_W-1:0] pdata_o,
    output logic [31:0]             wb_dat_o,
    output logic                    wb_ack_o
);

    import sobel_pkg::*;

    sobel_ctrl_u ctrl_w;

    // window bus between the line buffers and the kernel
    sobel_window_if win_if ();

    sobel_line_window u_window (
        .pclk_i  (pclk_i),
        .rst_i   (rst_i),
        .fsync_i (fsync_i),
        .rsync_i (rsync_i),
        .pdata_i (pdata_i),
        .win_o   (win_if.source)
    );

    sobel_kernel u_kernel (
        .pclk_i  (pclk_i),
        .rst_i   (rst_i),
        .ctrl_i  (ctrl_w),
        .win_i   (win_if.sink),
        .fsync_o (fsync_o),
        .rsync_o (rsync_o),
        .pdata_o (pdata_o)
    );

    // the frame counter watches the outgoing fsync
    sobel_wb_regs u_regs (
        .pclk_i   (pclk_i),
        .rst_i    (rst_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .fsync_i  (fsync_o),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .ctrl_o   (ctrl_w)
    );

endmodule

// File: verilog/sobel_kernel.sv
/*
 * Pipelined Sobel kernel
 * Gradient, absolute value, sum with saturation and mode select, output register
 */

`timescale 1ns/1ps
`include "sobel_defs.svh"

module sobel_kernel (
    input  logic                    pclk_i,
    input  logic                    rst_i,
    input  sobel_pkg::sobel_ctrl_u  ctrl_i,
    sobel_window_if.sink            win_i,
    output logic                    fsync_o,
    output logic                    rsync_o,
    output logic [`SOBEL_PIX_W-1:0] pdata_o
);

    import sobel_pkg::*;

    localparam int MAG_W = $bits(sobel_mag_t);

    // weighted column and row sums, each fits without sign
    logic [MAG_W-1:0] right_sum;
    logic [MAG_W-1:0] left_sum;
    logic [MAG_W-1:0] bottom_sum;
    logic [MAG_W-1:0] top_sum;

    sobel_mag_t gx_q;
    sobel_mag_t gy_q;
    sobel_mag_t abs_x_q;
    sobel_mag_t abs_y_q;

    // the sum of two magnitudes needs one bit more than either of them
    logic [MAG_W:0]          sum_w;
    logic [`SOBEL_PIX_W-1:0] sat_w;
    logic [`SOBEL_PIX_W-1:0] mode_w;

    // the newest pixel rides along so bypass keeps the stream delay
    logic [`SOBEL_PIX_W-1:0] pass_s1_q;
    logic [`SOBEL_PIX_W-1:0] pass_s2_q;
    logic [`SOBEL_PIX_W-1:0] pix_s3_q;

    logic [3:0] fsync_sr;
    logic [3:0] rsync_sr;

    assign right_sum  = {3'b000, win_i.p3} + {2'b00, win_i.p6, 1'b0} + {3'b000, win_i.p9};
    assign left_sum   = {3'b000, win_i.p1} + {2'b00, win_i.p4, 1'b0} + {3'b000, win_i.p7};
    assign bottom_sum = {3'b000, win_i.p7} + {2'b00, win_i.p8, 1'b0} + {3'b000, win_i.p9};
    assign top_sum    = {3'b000, win_i.p1} + {2'b00, win_i.p2, 1'b0} + {3'b000, win_i.p3};

    // stage 1 forms Gx and Gy as two's complement differences
    always_ff @(posedge pclk_i) begin
        gx_q      <= right_sum - left_sum;
        gy_q      <= bottom_sum - top_sum;
        pass_s1_q <= win_i.p9;
    end

    // stage 2 takes absolute values, the largest negative sum still fits
    always_ff @(posedge pclk_i) begin
        abs_x_q   <= (gx_q < 0) ? -gx_q : gx_q;
        abs_y_q   <= (gy_q < 0) ? -gy_q : gy_q;
        pass_s2_q <= pass_s1_q;
    end

    assign sum_w = {1'b0, abs_x_q} + {1'b0, abs_y_q};

    // anything above the pixel range clips to white
    assign sat_w = (sum_w[MAG_W:`SOBEL_PIX_W] != '0) ? '1 : sum_w[`SOBEL_PIX_W-1:0];

    // disabled passes the pixel through and binary mode compares the clipped sum
    always_comb begin
        if (!ctrl_i.f.enable) begin
            mode_w = pass_s2_q;
        end else if (ctrl_i.f.binary) begin
            mode_w = (sat_w > ctrl_i.f.threshold) ? '1 : '0;
        end else begin
            mode_w = sat_w;
        end
    end

    // stage 3 holds the chosen pixel
    always_ff @(posedge pclk_i) begin
        pix_s3_q <= mode_w;
    end

    // stage 4 is the output register, cleared so the bus is quiet after reset
    always_ff @(posedge pclk_i) begin
        if (rst_i) begin
            pdata_o <= '0;
        end else begin
            pdata_o <= pix_s3_q;
        end
    end

    // four windows are in flight so the syncs wait four cycles too
    always_ff @(posedge pclk_i) begin
        if (rst_i) begin
            fsync_sr <= '0;
            rsync_sr <= '0;
        end else begin
            fsync_sr <= {fsync_sr[2:0], win_i.fsync};
            rsync_sr <= {rsync_sr[2:0], win_i.rsync};
        end
    end

    assign fsync_o = fsync_sr[3];
    assign rsync_o = rsync_sr[3];

endmodule

// File: verilog/sobel_line_window.sv
/*
 * Line buffer window generator
 * Keeps the two previous rows and forms a zero-filled 3x3 neighbourhood
 * around every incoming pixel, one cycle after the pixel arrives
 */

`timescale 1ns/1ps
`include "sobel_defs.svh"

module sobel_line_window (
    input  logic                    pclk_i,
    input  logic                    rst_i,
    input  logic                    fsync_i,
    input  logic                    rsync_i,
    input  logic [`SOBEL_PIX_W-1:0] pdata_i,
    sobel_window_if.source          win_o
);

    localparam int COL_W = $clog2(`SOBEL_MAX_W);

    // row n-1 and row n-2 of the current frame
    logic [`SOBEL_PIX_W-1:0] line_prev  [0:`SOBEL_MAX_W-1];
    logic [`SOBEL_PIX_W-1:0] line_prev2 [0:`SOBEL_MAX_W-1];

    logic [COL_W-1:0] col_q;
    // number of rows stored since fsync rose, saturates at two
    logic [1:0]       rows_q;
    logic             fsync_q;
    logic             rsync_q;

    // asynchronous reads so the window is only one register away from the pixel
    logic [`SOBEL_PIX_W-1:0] prev_rd;
    logic [`SOBEL_PIX_W-1:0] prev2_rd;
    logic [`SOBEL_PIX_W-1:0] mid_in;
    logic [`SOBEL_PIX_W-1:0] top_in;

    // column shift registers, index 0 is the right column of the window
    logic [2:0][`SOBEL_PIX_W-1:0] top_sr;
    logic [2:0][`SOBEL_PIX_W-1:0] mid_sr;
    logic [2:0][`SOBEL_PIX_W-1:0] bot_sr;

    assign prev_rd  = line_prev[col_q];
    assign prev2_rd = line_prev2[col_q];

    // rows that do not exist yet in this frame read as zero
    assign mid_in = (rows_q != 2'd0) ? prev_rd : '0;
    assign top_in = (rows_q == 2'd2) ? prev2_rd : '0;

    // the column counter follows the pixel position inside the active row
    always_ff @(posedge pclk_i) begin
        if (rst_i || !rsync_i) begin
            col_q <= '0;
        end else begin
            col_q <= col_q + 1'b1;
        end
    end

    // count finished rows on the falling edge of rsync
    always_ff @(posedge pclk_i) begin
        if (rst_i || !fsync_i) begin
            rows_q <= 2'd0;
        end else if (rsync_q && !rsync_i && rows_q != 2'd2) begin
            rows_q <= rows_q + 2'd1;
        end
    end

    // syncs get the same single cycle of delay as the window
    always_ff @(posedge pclk_i) begin
        if (rst_i) begin
            fsync_q <= 1'b0;
            rsync_q <= 1'b0;
        end else begin
            fsync_q <= fsync_i;
            rsync_q <= rsync_i;
        end
    end

    // each column moves one row up, the oldest row falls out
    always_ff @(posedge pclk_i) begin
        if (rsync_i) begin
            line_prev[col_q]  <= pdata_i;
            line_prev2[col_q] <= prev_rd;
        end
    end

    // the shift registers are emptied between rows, which gives the
    // zero left border for the first two pixels of every row
    always_ff @(posedge pclk_i) begin
        if (!rsync_i) begin
            top_sr <= '0;
            mid_sr <= '0;
            bot_sr <= '0;
        end else begin
            top_sr <= {top_sr[1:0], top_in};
            mid_sr <= {mid_sr[1:0], mid_in};
            bot_sr <= {bot_sr[1:0], pdata_i};
        end
    end

    assign win_o.fsync = fsync_q;
    assign win_o.rsync = rsync_q;

    // left column is the oldest entry of each shift register
    assign win_o.p1 = top_sr[2];
    assign win_o.p2 = top_sr[1];
    assign win_o.p3 = top_sr[0];
    assign win_o.p4 = mid_sr[2];
    assign win_o.p5 = mid_sr[1];
    assign win_o.p6 = mid_sr[0];
    assign win_o.p7 = bot_sr[2];
    assign win_o.p8 = bot_sr[1];
    assign win_o.p9 = bot_sr[0];

endmodule

// File: verilog/sobel_pkg.sv
/*
 * Sobel edge subsystem types
 * Control word layout shared by the register block and the kernel,
 * and the signed gradient type used along the kernel pipeline
 */

`include "sobel_defs.svh"

package sobel_pkg;

    // field view of the control word, bit 0 is the lowest field
    typedef struct packed {
        logic [15:0] rsvd_hi;
        logic [7:0]  threshold;
        logic [5:0]  rsvd_lo;
        logic        binary;
        logic        enable;
    } sobel_ctrl_fields_t;

    // software writes the raw word and the datapath reads the fields
    typedef union packed {
        logic [31:0]        raw;
        sobel_ctrl_fields_t f;
    } sobel_ctrl_u;

    // three extra bits hold the weighted sums of a 3x3 window
    // and their difference keeps its sign in the top bit
    typedef logic signed [`SOBEL_PIX_W+2:0] sobel_mag_t;

endpackage

// File: verilog/sobel_wb_regs.sv
/*
 * Wishbone classic register block
 * Holds the kernel control word and counts the frames leaving the subsystem
 */

`timescale 1ns/1ps
`include "sobel_defs.svh"

module sobel_wb_regs (
    input  logic                   pclk_i,
    input  logic                   rst_i,
    input  logic                   wb_cyc_i,
    input  logic                   wb_stb_i,
    input  logic                   wb_we_i,
    input  logic [3:0]             wb_adr_i,
    input  logic [31:0]            wb_dat_i,
    input  logic                   fsync_i,
    output logic [31:0]            wb_dat_o,
    output logic                   wb_ack_o,
    output sobel_pkg::sobel_ctrl_u ctrl_o
);

    // only enable, binary and threshold are backed by flops
    localparam logic [31:0] CTRL_MASK = 32'h0000_ff03;

    logic        req_w;
    logic        fsync_q;
    logic [31:0] fcnt_q;

    // a new request is one the slave has not acknowledged yet
    assign req_w = wb_cyc_i && wb_stb_i && !wb_ack_o;

    // ack follows the request by one cycle and drops right after
    always_ff @(posedge pclk_i) begin
        if (rst_i) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= req_w;
        end
    end

    // the write lands on the same edge that raises ack
    always_ff @(posedge pclk_i) begin
        if (rst_i) begin
            ctrl_o <= '0;
        end else if (req_w && wb_we_i && wb_adr_i == `SOBEL_ADDR_CTRL) begin
            ctrl_o.raw <= wb_dat_i & CTRL_MASK;
        end
    end

    // read data is captured with the request so it is valid together with ack
    always_ff @(posedge pclk_i) begin
        if (req_w) begin
            case (wb_adr_i)
                `SOBEL_ADDR_CTRL: wb_dat_o <= ctrl_o.raw;
                `SOBEL_ADDR_FCNT: wb_dat_o <= fcnt_q;
                default:          wb_dat_o <= '0;
            endcase
        end
    end

    // a frame is complete when the output fsync falls
    // writes to the counter address are simply not decoded
    always_ff @(posedge pclk_i) begin
        if (rst_i) begin
            fsync_q <= 1'b0;
            fcnt_q  <= '0;
        end else begin
            fsync_q <= fsync_i;
            if (fsync_q && !fsync_i) begin
                fcnt_q <= fcnt_q + 32'd1;
            end
        end
    end

endmodule

// File: verilog/sobel_window_if.sv
/*
 * 3x3 pixel window bus
 * Carries one neighbourhood per clock together with the frame and row syncs
 */

`timescale 1ns/1ps
`include "sobel_defs.svh"

interface sobel_window_if;

    // syncs aligned with the window they travel with
    logic fsync;
    logic rsync;

    // row-major neighbourhood, p1 is top left and p9 the newest pixel
    logic [`SOBEL_PIX_W-1:0] p1, p2, p3;
    logic [`SOBEL_PIX_W-1:0] p4, p5, p6;
    logic [`SOBEL_PIX_W-1:0] p7, p8, p9;

    // the window generator drives everything
    modport source (
        output fsync, rsync,
        output p1, p2, p3, p4, p5, p6, p7, p8, p9
    );

    // the kernel only reads, there is no handshake back
    modport sink (
        input fsync, rsync,
        input p1, p2, p3, p4, p5, p6, p7, p8, p9
    );

endinterface
